//--- lsu_obi_top.f
src/lsu_pkg.sv
src/lsu_trans_if.sv
src/lsu_req_stage.sv
src/lsu_obi_adapter.sv
src/lsu_resp_stage.sv
src/lsu_obi_top.sv
verif/obi_mem_model.sv
verif/lsu_obi_tb.sv

//--- Makefile
SIM      = verilator
TOP      = lsu_obi_tb
FILELIST = lsu_obi_top.f
OBJ_DIR  = obj_dir
FLAGS    = --binary --timing --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- verif/lsu_obi_tb.sv
/*
 * Testbench for the load/store OBI data path
 * - clock, reset, stimulus table applied back to back
 * - expected result queue with typed compare tasks
 * - OBI memory model with random delays and integrity checks
 */

module lsu_obi_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_STIM        = 26;
  localparam int N_PASS        = 2;
  localparam int N_TOTAL       = N_STIM * N_PASS;
  localparam int READY_TIMEOUT = 50;
  localparam int DRAIN_TIMEOUT = 200;

  // One request with its expected result
  typedef struct packed {
    lsu_pkg::lsu_op_e op;
    logic [31:0]      addr;
    logic [31:0]      wdata;
    logic             corrupt;
    logic [31:0]      exp_data;
    logic             exp_err;
    logic             exp_chk_err;
  } stim_t;

  logic                       clk = 1'b0;
  logic                       rst_n;
  logic                       lsu_valid;
  logic                       lsu_ready;
  lsu_pkg::lsu_op_e           lsu_op;
  logic [31:0]                lsu_addr;
  logic [31:0]                lsu_wdata;
  logic                       obi_req;
  logic                       obi_reqpar;
  logic                       obi_gnt;
  logic [31:0]                obi_addr;
  logic                       obi_we;
  logic [3:0]                 obi_be;
  logic [31:0]                obi_wdata;
  logic [lsu_pkg::ACHK_W-1:0] obi_achk;
  logic                       obi_rvalid;
  logic [31:0]                obi_rdata;
  logic                       obi_err;
  logic [lsu_pkg::RCHK_W-1:0] obi_rchk;
  logic                       result_valid;
  logic [31:0]                result_data;
  logic                       result_err;
  logic                       result_chk_err;
  logic [63:0]                corrupt_map;
  logic                       integrity_err;

  stim_t exp_q [$];
  stim_t exp_head;
  int    n_checked = 0;

  // op, addr, wdata, corrupt, expected data, err, chk_err
  stim_t stim_tab [N_STIM] = '{
    '{lsu_pkg::SW,  32'h10,  32'h876543A1, 1'b0, 32'h00000000, 1'b0, 1'b0},
    '{lsu_pkg::LW,  32'h10,  32'h00000000, 1'b0, 32'h876543A1, 1'b0, 1'b0},
    '{lsu_pkg::SB,  32'h11,  32'h000000F0, 1'b0, 32'h00000000, 1'b0, 1'b0},
    '{lsu_pkg::SH,  32'h12,  32'h00001234, 1'b0, 32'h00000000, 1'b0, 1'b0},
    '{lsu_pkg::LW,  32'h10,  32'h00000000, 1'b0, 32'h1234F0A1, 1'b0, 1'b0},
    '{lsu_pkg::LB,  32'h11,  32'h00000000, 1'b0, 32'hFFFFFFF0, 1'b0, 1'b0},
    '{lsu_pkg::LBU, 32'h11,  32'h00000000, 1'b0, 32'h000000F0, 1'b0, 1'b0},
    '{lsu_pkg::LB,  32'h10,  32'h00000000, 1'b0, 32'hFFFFFFA1, 1'b0, 1'b0},
    '{lsu_pkg::LH,  32'h12,  32'h00000000, 1'b0, 32'h00001234, 1'b0, 1'b0},
    '{lsu_pkg::LH,  32'h10,  32'h00000000, 1'b0, 32'hFFFFF0A1, 1'b0, 1'b0},
    '{lsu_pkg::LHU, 32'h10,  32'h00000000, 1'b0, 32'h0000F0A1, 1'b0, 1'b0},
    '{lsu_pkg::LBU, 32'h13,  32'h00000000, 1'b0, 32'h00000012, 1'b0, 1'b0},
    '{lsu_pkg::SW,  32'h20,  32'h80FF7F01, 1'b0, 32'h00000000, 1'b0, 1'b0},
    '{lsu_pkg::LB,  32'h23,  32'h00000000, 1'b0, 32'hFFFFFF80, 1'b0, 1'b0},
    '{lsu_pkg::LB,  32'h22,  32'h00000000, 1'b0, 32'hFFFFFFFF, 1'b0, 1'b0},
    '{lsu_pkg::LB,  32'h21,  32'h00000000, 1'b0, 32'h0000007F, 1'b0, 1'b0},
    '{lsu_pkg::LHU, 32'h22,  32'h00000000, 1'b0, 32'h000080FF, 1'b0, 1'b0},
    '{lsu_pkg::LH,  32'h22,  32'h00000000, 1'b0, 32'hFFFF80FF, 1'b0, 1'b0},
    '{lsu_pkg::LW,  32'h104, 32'h00000000, 1'b0, 32'h00000000, 1'b1, 1'b0},
    '{lsu_pkg::SW,  32'h200, 32'hDEADBEEF, 1'b0, 32'h00000000, 1'b1, 1'b0},
    '{lsu_pkg::LW,  32'h10,  32'h00000000, 1'b1, 32'h1234F0A1, 1'b0, 1'b1},
    '{lsu_pkg::SB,  32'h20,  32'h00000055, 1'b1, 32'h00000000, 1'b0, 1'b1},
    '{lsu_pkg::LW,  32'h20,  32'h00000000, 1'b0, 32'h80FF7F55, 1'b0, 1'b0},
    '{lsu_pkg::SH,  32'h3C,  32'h9876ABCD, 1'b0, 32'h00000000, 1'b0, 1'b0},
    '{lsu_pkg::LH,  32'h3C,  32'h00000000, 1'b0, 32'hFFFFABCD, 1'b0, 1'b0},
    '{lsu_pkg::LW,  32'h3C,  32'h00000000, 1'b0, 32'h0000ABCD, 1'b0, 1'b0}
  };

  always #2 clk = ~clk;

  lsu_obi_top #(
    .OUTSTANDING_DEPTH (2)
  ) u_dut (
    .clk              (clk),
    .rst_n_i          (rst_n),
    .lsu_valid_i      (lsu_valid),
    .lsu_ready_o      (lsu_ready),
    .lsu_op_i         (lsu_op),
    .lsu_addr_i       (lsu_addr),
    .lsu_wdata_i      (lsu_wdata),
    .obi_req_o        (obi_req),
    .obi_reqpar_o     (obi_reqpar),
    .obi_gnt_i        (obi_gnt),
    .obi_addr_o       (obi_addr),
    .obi_we_o         (obi_we),
    .obi_be_o         (obi_be),
    .obi_wdata_o      (obi_wdata),
    .obi_achk_o       (obi_achk),
    .obi_rvalid_i     (obi_rvalid),
    .obi_rdata_i      (obi_rdata),
    .obi_err_i        (obi_err),
    .obi_rchk_i       (obi_rchk),
    .result_valid_o   (result_valid),
    .result_data_o    (result_data),
    .result_err_o     (result_err),
    .result_chk_err_o (result_chk_err)
  );

  obi_mem_model u_mem (
    .clk             (clk),
    .rst_n_i         (rst_n),
    .obi_req_i       (obi_req),
    .obi_reqpar_i    (obi_reqpar),
    .obi_gnt_o       (obi_gnt),
    .obi_addr_i      (obi_addr),
    .obi_we_i        (obi_we),
    .obi_be_i        (obi_be),
    .obi_wdata_i     (obi_wdata),
    .obi_achk_i      (obi_achk),
    .obi_rvalid_o    (obi_rvalid),
    .obi_rdata_o     (obi_rdata),
    .obi_err_o       (obi_err),
    .obi_rchk_o      (obi_rchk),
    .corrupt_map_i   (corrupt_map),
    .integrity_err_o (integrity_err)
  );

  //////////////////////////////////////////////////////////////////////
  // Failure handling and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_data(input logic [31:0] exp_val, input logic [31:0] act_val);
    if (act_val !== exp_val)
      abort_run($sformatf("** Error at %0t: result_data_o expected %h, got %h",
                          $time, exp_val, act_val));
  endtask

  task automatic check_err(input logic exp_val, input logic act_val);
    if (act_val !== exp_val)
      abort_run($sformatf("** Error at %0t: result_err_o expected %b, got %b",
                          $time, exp_val, act_val));
  endtask

  task automatic check_chk_err(input logic exp_val, input logic act_val);
    if (act_val !== exp_val)
      abort_run($sformatf("** Error at %0t: result_chk_err_o expected %b, got %b",
                          $time, exp_val, act_val));
  endtask

  // Memory model flags bad achk or reqpar
  always @(posedge integrity_err)
    abort_run("The OBI memory model saw a wrong integrity bit on the A channel");

  // Results in request order, sampled away from the rising edge
  always @(negedge clk)
  begin
    if (rst_n === 1'b1 && result_valid === 1'b1)
    begin
      if (exp_q.size() == 0)
        abort_run("A result arrived with no request outstanding");
      else
      begin
        exp_head = exp_q.pop_front();
        check_data(exp_head.exp_data, result_data);
        check_err(exp_head.exp_err, result_err);
        check_chk_err(exp_head.exp_chk_err, result_chk_err);
        n_checked++;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    stim_t entry;
    int    wait_cnt;
    rst_n     = 1'b0;
    lsu_valid = 1'b0;
    lsu_op    = lsu_pkg::LW;
    lsu_addr  = '0;
    lsu_wdata = '0;
    // Transfer k takes its corrupt flag from its table entry
    corrupt_map = '0;
    for (int k = 0; k < N_TOTAL; k++)
      corrupt_map = corrupt_map | (64'(stim_tab[k % N_STIM].corrupt) << k);
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int k = 0; k < N_TOTAL; k++)
    begin
      entry = stim_tab[k % N_STIM];
      @(negedge clk);
      lsu_valid = 1'b1;
      lsu_op    = entry.op;
      lsu_addr  = entry.addr;
      lsu_wdata = entry.wdata;
      #1;
      wait_cnt = 0;
      while (lsu_ready !== 1'b1)
      begin
        if (wait_cnt == READY_TIMEOUT)
          abort_run("Timed out waiting for lsu_ready_o");
        else
        begin
          wait_cnt++;
          @(negedge clk);
          #1;
        end
      end
      // Taken at the coming rising edge
      exp_q.push_back(entry);
    end

    @(negedge clk);
    lsu_valid = 1'b0;
    wait_cnt  = 0;
    while (n_checked < N_TOTAL && wait_cnt < DRAIN_TIMEOUT)
    begin
      @(negedge clk);
      #1;
      wait_cnt++;
    end
    if (n_checked < N_TOTAL)
      abort_run($sformatf("Timed out with %0d of %0d results received", n_checked, N_TOTAL));
    else
    begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

//--- verif/obi_mem_model.sv
/*
 * OBI data slave memory, 64 words
 * - grant after 0 to 2 cycles, response after 1 to 3 cycles
 * - Galois LFSR delays, two bits per draw
 * - achk and reqpar check, rchk generation with optional corruption
 * - bus error at 0x100 and above
 */

module obi_mem_model (
  input  logic                       clk,
  input  logic                       rst_n_i,
  input  logic                       obi_req_i,
  input  logic                       obi_reqpar_i,
  output logic                       obi_gnt_o,
  input  logic [31:0]                obi_addr_i,
  input  logic                       obi_we_i,
  input  logic [3:0]                 obi_be_i,
  input  logic [31:0]                obi_wdata_i,
  input  logic [lsu_pkg::ACHK_W-1:0] obi_achk_i,
  output logic                       obi_rvalid_o,
  output logic [31:0]                obi_rdata_o,
  output logic                       obi_err_o,
  output logic [lsu_pkg::RCHK_W-1:0] obi_rchk_o,
  input  logic [63:0]                corrupt_map_i,
  output logic                       integrity_err_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [31:0]                mem [64];
  logic [15:0]                lfsr_state;
  int                         cycle;
  int                         gnt_wait;
  logic                       gnt_armed;
  logic [5:0]                 xfer_idx;

  // Pending responses, oldest first
  logic [31:0]                rdata_q [$];
  logic                       err_q [$];
  logic [lsu_pkg::RCHK_W-1:0] rchk_q [$];
  int                         due_q [$];

  // Driven registers, known from time zero
  logic                       gnt_r    = 1'b0;
  logic                       rvalid_r = 1'b0;
  logic [31:0]                rdata_r  = '0;
  logic                       err_r    = 1'b0;
  logic [lsu_pkg::RCHK_W-1:0] rchk_r   = '0;
  logic                       fail_r   = 1'b0;

  assign obi_gnt_o       = gnt_r;
  assign obi_rvalid_o    = rvalid_r;
  assign obi_rdata_o     = rdata_r;
  assign obi_err_o       = err_r;
  assign obi_rchk_o      = rchk_r;
  assign integrity_err_o = fail_r;

  //////////////////////////////////////////////////////////////////////
  // Random delays
  //////////////////////////////////////////////////////////////////////

  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // Two bits folded onto 0..2
  task automatic draw_delay(output int d);
    logic [1:0] v;
    v = 2'b00;
    for (int b = 0; b < 2; b++)
    begin
      v = {v[0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    d = int'(v % 2'd3);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Integrity rules
  //////////////////////////////////////////////////////////////////////

  // prot is data/machine, memtype and dbg are zero, atop is zero
  function automatic logic [11:0] expect_achk(logic [31:0] addr, logic we,
                                              logic [3:0] be, logic [31:0] wdata);
    logic [11:0] c;
    c[11] = ^wdata[31:24];
    c[10] = ^wdata[23:16];
    c[9]  = ^wdata[15:8];
    c[8]  = ^wdata[7:0];
    c[7]  = 1'b0;
    c[6]  = ~^1'b0;
    c[5]  = ~^{be, we};
    c[4]  = ~^{3'b111, 2'b00};
    c[3]  = ^addr[31:24];
    c[2]  = ^addr[23:16];
    c[1]  = ^addr[15:8];
    c[0]  = ^addr[7:0];
    return c;
  endfunction

  function automatic logic [4:0] expect_rchk(logic [31:0] rdata, logic err);
    return {~^err, ^rdata[31:24], ^rdata[23:16], ^rdata[15:8], ^rdata[7:0]};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Transfer handling
  //////////////////////////////////////////////////////////////////////

  // Memory access happens at grant, response is queued
  task automatic accept_transfer();
    logic [31:0] rdata;
    logic        err;
    logic [4:0]  rchk;
    int          d;
    // Writes and bus errors answer with junk read data
    rdata = obi_addr_i ^ 32'hA5A55A5A;
    err   = (obi_addr_i >= 32'h100);
    if (!err && obi_we_i)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (obi_be_i[b])
          mem[obi_addr_i[7:2]][8*b +: 8] = obi_wdata_i[8*b +: 8];
      end
    end
    else if (!err)
      rdata = mem[obi_addr_i[7:2]];
    rchk = expect_rchk(rdata, err);
    if (corrupt_map_i[xfer_idx])
      rchk[0] = ~rchk[0];
    draw_delay(d);
    rdata_q.push_back(rdata);
    err_q.push_back(err);
    rchk_q.push_back(rchk);
    due_q.push_back(cycle + 1 + d);
    xfer_idx = xfer_idx + 1'b1;
  endtask

  // DUT outputs are stable here, new values land before the next rising edge
  always @(negedge clk)
  begin
    logic gnt_next;
    if (!rst_n_i)
    begin
      lfsr_state = 16'd98;
      cycle      = 0;
      gnt_wait   = 0;
      gnt_armed  = 1'b0;
      xfer_idx   = '0;
      for (int i = 0; i < 64; i++)
        mem[i] = '0;
      rdata_q.delete();
      err_q.delete();
      rchk_q.delete();
      due_q.delete();
      gnt_r    <= 1'b0;
      rvalid_r <= 1'b0;
    end
    else
    begin
      cycle    = cycle + 1;
      gnt_next = 1'b0;
      if (obi_reqpar_i == obi_req_i)
      begin
        $display("OBI reqpar is not the inverse of req at %0t", $time);
        fail_r <= 1'b1;
      end
      if (obi_req_i)
      begin
        if (obi_achk_i != expect_achk(obi_addr_i, obi_we_i, obi_be_i, obi_wdata_i))
        begin
          $display("OBI achk does not match the A channel payload at %0t", $time);
          fail_r <= 1'b1;
        end
        // New delay for each request that is not yet granted
        if (!gnt_armed)
        begin
          draw_delay(gnt_wait);
          gnt_armed = 1'b1;
        end
        if (gnt_wait == 0)
        begin
          gnt_next  = 1'b1;
          gnt_armed = 1'b0;
          accept_transfer();
        end
        else
          gnt_wait = gnt_wait - 1;
      end
      gnt_r <= gnt_next;
      // One response per cycle, in grant order
      if (due_q.size() > 0 && due_q[0] <= cycle)
      begin
        rvalid_r <= 1'b1;
        rdata_r  <= rdata_q.pop_front();
        err_r    <= err_q.pop_front();
        rchk_r   <= rchk_q.pop_front();
        void'(due_q.pop_front());
      end
      else
        rvalid_r <= 1'b0;
    end
  end

endmodule

//--- src/lsu_obi_top.sv
/*
 * Load/store OBI data path top level
 * - request stage, OBI adapter and response stage
 * - OBI A and R channel structs split into plain ports
 */

module lsu_obi_top #(
  parameter int unsigned OUTSTANDING_DEPTH = 2
) (
  input  logic                       clk,
  input  logic                       rst_n_i,

  // Load/store requests
  input  logic                       lsu_valid_i,
  output logic                       lsu_ready_o,
  input  lsu_pkg::lsu_op_e           lsu_op_i,
  input  logic [31:0]                lsu_addr_i,
  input  logic [31:0]                lsu_wdata_i,

  // OBI A channel
  output logic                       obi_req_o,
  output logic                       obi_reqpar_o,
  input  logic                       obi_gnt_i,
  output logic [31:0]                obi_addr_o,
  output logic                       obi_we_o,
  output logic [3:0]                 obi_be_o,
  output logic [31:0]                obi_wdata_o,
  output logic [lsu_pkg::ACHK_W-1:0] obi_achk_o,

  // OBI R channel
  input  logic                       obi_rvalid_i,
  input  logic [31:0]                obi_rdata_i,
  input  logic                       obi_err_i,
  input  logic [lsu_pkg::RCHK_W-1:0] obi_rchk_i,

  // Results, always accepted
  output logic                       result_valid_o,
  output logic [31:0]                result_data_o,
  output logic                       result_err_o,
  output logic                       result_chk_err_o
);

  lsu_pkg::obi_data_req_t  req_payload;
  lsu_pkg::obi_data_resp_t resp_payload;
  lsu_pkg::obi_data_resp_t resp;
  logic                    resp_valid;

  lsu_trans_if u_trans_if ();

  lsu_req_stage u_req_stage (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .lsu_valid_i (lsu_valid_i),
    .lsu_ready_o (lsu_ready_o),
    .lsu_op_i    (lsu_op_i),
    .lsu_addr_i  (lsu_addr_i),
    .lsu_wdata_i (lsu_wdata_i),
    .trans_if    (u_trans_if.req)
  );

  lsu_obi_adapter u_obi_adapter (
    .clk                (clk),
    .rst_n_i            (rst_n_i),
    .trans_if           (u_trans_if.adapter),
    .obi_req_o          (obi_req_o),
    .obi_reqpar_o       (obi_reqpar_o),
    .obi_gnt_i          (obi_gnt_i),
    .obi_req_payload_o  (req_payload),
    .obi_rvalid_i       (obi_rvalid_i),
    .obi_resp_payload_i (resp_payload),
    .resp_valid_o       (resp_valid),
    .resp_o             (resp)
  );

  lsu_resp_stage #(
    .OUTSTANDING_DEPTH (OUTSTANDING_DEPTH)
  ) u_resp_stage (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .trans_if         (u_trans_if.resp),
    .resp_valid_i     (resp_valid),
    .resp_i           (resp),
    .result_valid_o   (result_valid_o),
    .result_data_o    (result_data_o),
    .result_err_o     (result_err_o),
    .result_chk_err_o (result_chk_err_o)
  );

  ////////////////////////////////////////////////////////////////////
  // OBI struct split
  ////////////////////////////////////////////////////////////////////

  // prot, memtype and dbg are constants and only enter achk
  assign obi_addr_o  = req_payload.addr;
  assign obi_we_o    = req_payload.we;
  assign obi_be_o    = req_payload.be;
  assign obi_wdata_o = req_payload.wdata;
  assign obi_achk_o  = req_payload.achk;

  assign resp_payload = '{rdata: obi_rdata_i, err: obi_err_i, rchk: obi_rchk_i};

endmodule

//--- src/lsu_resp_stage.sv
/*
 * Load/store response stage
 * - in-order FIFO of attributes for outstanding transfers
 * - rchk recompute and compare
 * - load lane select with sign or zero extension
 * - registered result, one per response
 */

module lsu_resp_stage #(
  parameter int unsigned OUTSTANDING_DEPTH = 2
) (
  input  logic                    clk,
  input  logic                    rst_n_i,
  lsu_trans_if.resp               trans_if,
  input  logic                    resp_valid_i,
  input  lsu_pkg::obi_data_resp_t resp_i,
  output logic                    result_valid_o,
  output logic [31:0]             result_data_o,
  output logic                    result_err_o,
  output logic                    result_chk_err_o
);

  localparam int unsigned PTR_W = (OUTSTANDING_DEPTH > 1) ? $clog2(OUTSTANDING_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(OUTSTANDING_DEPTH + 1);

  lsu_pkg::lsu_attr_t attr_mem [OUTSTANDING_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               push;
  logic               pop;
  lsu_pkg::lsu_attr_t head;

  logic [31:0]        shifted;
  logic [31:0]        load_data;
  logic               chk_err;

  ////////////////////////////////////////////////////////////////////
  // Attribute FIFO
  ////////////////////////////////////////////////////////////////////

  assign push = trans_if.trans_valid && trans_if.trans_ready;
  // Every response belongs to the oldest entry
  assign pop  = resp_valid_i;

  assign trans_if.attr_full = (count == CNT_W'(OUTSTANDING_DEPTH));
  assign head               = attr_mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (push)
      attr_mem[wr_ptr] <= trans_if.attr;
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == PTR_W'(OUTSTANDING_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(OUTSTANDING_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Response check and load alignment
  ////////////////////////////////////////////////////////////////////

  assign chk_err = (lsu_pkg::calc_rchk(resp_i.rdata, resp_i.err) != resp_i.rchk);

  // Addressed lane moved down to bit 0
  assign shifted = resp_i.rdata >> {head.offset, 3'b000};

  always_comb
  begin
    case (head.size)
      lsu_pkg::SIZE_BYTE: load_data = {{24{head.sign & shifted[7]}}, shifted[7:0]};
      lsu_pkg::SIZE_HALF: load_data = {{16{head.sign & shifted[15]}}, shifted[15:0]};
      default:            load_data = resp_i.rdata;
    endcase
    // Stores and bus errors return zero
    if (head.we || resp_i.err)
      load_data = '0;
  end

  ////////////////////////////////////////////////////////////////////
  // Result register
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      result_valid_o   <= 1'b0;
      result_err_o     <= 1'b0;
      result_chk_err_o <= 1'b0;
    end
    else
    begin
      result_valid_o   <= resp_valid_i;
      result_err_o     <= resp_valid_i && resp_i.err;
      result_chk_err_o <= resp_valid_i && chk_err;
    end
  end

  always_ff @(posedge clk)
  begin
    if (resp_valid_i)
      result_data_o <= load_data;
  end

endmodule

//--- src/lsu_obi_adapter.sv
/*
 * OBI data adapter
 * - A channel driven straight from the transaction
 * - achk integrity vector and inverted reqpar
 * - R channel returned unchanged as the response
 */

module lsu_obi_adapter (
  input  logic                    clk,
  input  logic                    rst_n_i,
  lsu_trans_if.adapter            trans_if,
  output logic                    obi_req_o,
  output logic                    obi_reqpar_o,
  input  logic                    obi_gnt_i,
  output lsu_pkg::obi_data_req_t  obi_req_payload_o,
  input  logic                    obi_rvalid_i,
  input  lsu_pkg::obi_data_resp_t obi_resp_payload_i,
  output logic                    resp_valid_o,
  output lsu_pkg::obi_data_resp_t resp_o
);

  ////////////////////////////////////////////////////////////////////
  // A channel
  ////////////////////////////////////////////////////////////////////

  // Transaction is held stable until gnt, so it maps onto OBI directly
  always_comb
  begin
    obi_req_o              = trans_if.trans_valid;
    obi_req_payload_o      = trans_if.trans;
    // Integrity computed on the outgoing payload
    obi_req_payload_o.achk = lsu_pkg::calc_achk(trans_if.trans);
  end

  assign obi_reqpar_o = !obi_req_o;

  // Grant completes the transfer
  assign trans_if.trans_ready = obi_gnt_i;

  ////////////////////////////////////////////////////////////////////
  // R channel
  ////////////////////////////////////////////////////////////////////

  // Consumer always ready, nothing stored here
  assign resp_valid_o = obi_rvalid_i;
  assign resp_o       = obi_resp_payload_i;

endmodule

//--- src/lsu_req_stage.sv
/*
 * Load/store request stage
 * - one transfer register, refilled as the adapter accepts it
 * - opcode decode into we, size and sign
 * - byte enables and lane-shifted store data
 */

module lsu_req_stage (
  input  logic             clk,
  input  logic             rst_n_i,
  input  logic             lsu_valid_i,
  output logic             lsu_ready_o,
  input  lsu_pkg::lsu_op_e lsu_op_i,
  input  logic [31:0]      lsu_addr_i,
  input  logic [31:0]      lsu_wdata_i,
  lsu_trans_if.req         trans_if
);

  logic                   valid_q;
  lsu_pkg::obi_data_req_t trans_q;
  lsu_pkg::lsu_attr_t     attr_q;
  logic                   accept;

  // Decoded request
  logic       dec_we;
  logic [1:0] dec_size;
  logic       dec_sign;
  logic [1:0] offset;
  logic [3:0] dec_be;

  ////////////////////////////////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////////////////////////////////

  assign offset = lsu_addr_i[1:0];

  always_comb
  begin
    dec_we   = 1'b0;
    dec_sign = 1'b0;
    dec_size = lsu_pkg::SIZE_WORD;
    case (lsu_op_i)
      lsu_pkg::LB:  begin dec_size = lsu_pkg::SIZE_BYTE; dec_sign = 1'b1; end
      lsu_pkg::LBU: dec_size = lsu_pkg::SIZE_BYTE;
      lsu_pkg::LH:  begin dec_size = lsu_pkg::SIZE_HALF; dec_sign = 1'b1; end
      lsu_pkg::LHU: dec_size = lsu_pkg::SIZE_HALF;
      lsu_pkg::SB:  begin dec_size = lsu_pkg::SIZE_BYTE; dec_we = 1'b1; end
      lsu_pkg::SH:  begin dec_size = lsu_pkg::SIZE_HALF; dec_we = 1'b1; end
      lsu_pkg::SW:  dec_we = 1'b1;
      default:      dec_size = lsu_pkg::SIZE_WORD;
    endcase
  end

  // Byte enables shifted to the offset, upper lanes drop off when misaligned
  always_comb
  begin
    case (dec_size)
      lsu_pkg::SIZE_BYTE: dec_be = 4'b0001 << offset;
      lsu_pkg::SIZE_HALF: dec_be = 4'b0011 << offset;
      default:            dec_be = 4'b1111;
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // Transfer register
  ////////////////////////////////////////////////////////////////////

  // Held transfer leaves when the adapter takes it
  assign accept      = trans_if.trans_valid && trans_if.trans_ready;
  assign lsu_ready_o = !valid_q || accept;

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
      valid_q <= 1'b0;
    else if (lsu_ready_o)
      valid_q <= lsu_valid_i;
  end

  always_ff @(posedge clk)
  begin
    if (lsu_valid_i && lsu_ready_o)
    begin
      trans_q.addr    <= lsu_addr_i;
      trans_q.we      <= dec_we;
      trans_q.be      <= dec_be;
      // Store data moved into its byte lanes
      trans_q.wdata   <= lsu_wdata_i << {offset, 3'b000};
      trans_q.prot    <= lsu_pkg::PROT_DATA_M;
      trans_q.memtype <= 2'b00;
      trans_q.dbg     <= 1'b0;
      trans_q.achk    <= '0;
      attr_q          <= '{we: dec_we, size: dec_size, sign: dec_sign, offset: offset};
    end
  end

  // Request held back while the attribute FIFO is full
  assign trans_if.trans_valid = valid_q && !trans_if.attr_full;
  assign trans_if.trans       = trans_q;
  assign trans_if.attr        = attr_q;

endmodule

//--- src/lsu_trans_if.sv
/*
 * Transaction link between request stage, OBI adapter and response stage
 * - transfer valid/ready handshake with the A channel payload
 * - attributes of the transfer and the FIFO full flag
 */

interface lsu_trans_if;

  // Transfer towards the OBI A channel
  logic                  trans_valid;
  lsu_pkg::obi_data_req_t trans;
  logic                  trans_ready;

  // Attributes pushed on acceptance
  lsu_pkg::lsu_attr_t    attr;
  // No room for another outstanding transfer
  logic                  attr_full;

  modport req (
    output trans_valid,
    output trans,
    output attr,
    input  trans_ready,
    input  attr_full
  );

  modport adapter (
    input  trans_valid,
    input  trans,
    output trans_ready
  );

  modport resp (
    input  trans_valid,
    input  trans_ready,
    input  attr,
    output attr_full
  );

endinterface

//--- src/lsu_pkg.sv
/*
 * Shared definitions for the load/store OBI data path
 * - load/store opcode enum and transfer size codes
 * - OBI A and R channel payload structs with integrity fields
 * - pending transfer attribute struct
 * - achk and rchk integrity functions
 */

package lsu_pkg;

  // Integrity vector widths
  localparam int unsigned ACHK_W = 12;
  localparam int unsigned RCHK_W = 5;

  // Transfer size codes, as held in lsu_attr_t.size
  localparam logic [1:0] SIZE_BYTE = 2'd0;
  localparam logic [1:0] SIZE_HALF = 2'd1;
  localparam logic [1:0] SIZE_WORD = 2'd2;

  // Data access in machine mode
  localparam logic [2:0] PROT_DATA_M = 3'b111;

  typedef enum logic [2:0] {
    LB,
    LBU,
    LH,
    LHU,
    LW,
    SB,
    SH,
    SW
  } lsu_op_e;

  // OBI A channel payload, 87 bits
  typedef struct packed {
    logic [31:0]       addr;
    logic              we;
    logic [3:0]        be;
    logic [31:0]       wdata;
    logic [2:0]        prot;
    logic [1:0]        memtype;
    logic              dbg;
    logic [ACHK_W-1:0] achk;
  } obi_data_req_t;

  // OBI R channel payload, 38 bits
  typedef struct packed {
    logic [31:0]       rdata;
    logic              err;
    logic [RCHK_W-1:0] rchk;
  } obi_data_resp_t;

  // Attributes kept per outstanding transfer
  typedef struct packed {
    logic       we;
    logic [1:0] size;
    logic       sign;
    logic [1:0] offset;
  } lsu_attr_t;

  ////////////////////////////////////////////////////////////////////
  // Integrity
  ////////////////////////////////////////////////////////////////////

  // A channel check bits, atop is always zero
  function automatic logic [ACHK_W-1:0] calc_achk(obi_data_req_t r);
    calc_achk = {^r.wdata[31:24], ^r.wdata[23:16], ^r.wdata[15:8], ^r.wdata[7:0],
                 ^6'b0,
                 ~^r.dbg,
                 ~^{r.be, r.we},
                 ~^{r.prot, r.memtype},
                 ^r.addr[31:24], ^r.addr[23:16], ^r.addr[15:8], ^r.addr[7:0]};
  endfunction

  // R channel check bits
  function automatic logic [RCHK_W-1:0] calc_rchk(logic [31:0] rdata, logic err);
    calc_rchk = {~^err, ^rdata[31:24], ^rdata[23:16], ^rdata[15:8], ^rdata[7:0]};
  endfunction

endpackage
